/* udp_axi_bridge.f */
+incdir+design
design/udp_axi_pkg.sv
design/sync_fifo.sv
design/cmd_parser.sv
design/wr_addr_issue.sv
design/wr_data_issue.sv
design/wr_resp_report.sv
design/udp_axi_bridge.sv
verif/tb_clock_gen.sv
verif/tb_udp_axi_bridge.sv

/* Makefile */
# Verilator build and run of the udp_axi_bridge testbench

TOP := tb_udp_axi_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f udp_axi_bridge.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* verif/tb_udp_axi_bridge.sv */
module tb_udp_axi_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    import udp_axi_pkg::*;

    localparam int NUM_ENTRIES = 8;
    localparam int BATCH       = 4;     // descriptors per command packet
    localparam int TIMEOUT     = 200;   // cycles allowed for any single wait

    typedef struct packed {
        logic [7:0]      opcode;
        logic            wr;
        axi_id_t         id;
        axi_len_t        len;
        axi_burst_t      burst;
        axi_addr_t       addr;
        logic [2:0]      nwords;    // payload words from 1 to 4
        udp_word_t [3:0] payload;
        axi_id_t         rid;       // id and response the slave returns
        axi_resp_t       rresp;
    } stim_t;

    logic        gmii_rx_clk;
    logic        rstn;
    logic        udp_rx_en;
    logic        udp_rx_done;
    udp_word_t   udp_rx_data;
    logic        udp_tx_start;
    logic [15:0] udp_tx_byte_num;
    udp_word_t   udp_tx_data;
    logic        udp_tx_req;
    logic        udp_tx_done;
    axi_id_t     m_awid;
    axi_addr_t   m_awaddr;
    axi_len_t    m_awlen;
    axi_burst_t  m_awburst;
    logic        m_awvalid;
    logic        m_awready;
    udp_word_t   m_wdata;
    logic        m_wlast;
    logic        m_wvalid;
    logic        m_wready;
    axi_id_t     m_bid;
    axi_resp_t   m_bresp;
    logic        m_bvalid;
    logic        m_bready;

    stim_t       stim [NUM_ENTRIES];
    udp_word_t   exp_resp [$];   // response words not yet read back
    logic [15:0] tx_bytes [$];   // byte count of each started udp packet
    int          aw_seen = 0;
    integer      seed = 32'h52d2;

    tb_clock_gen u_clock_gen (.gmii_rx_clk, .rstn);

    udp_axi_bridge dut (.*);

    // values sampled before the edge updates them
    always @(posedge gmii_rx_clk) begin
        if (m_awvalid && m_awready) begin
            aw_seen++;
        end
        if (udp_tx_start) begin
            tx_bytes.push_back(udp_tx_byte_num);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge gmii_rx_clk);
        #10;
    endtask

    task automatic check_aw(input axi_id_t id, input axi_len_t len, input axi_burst_t burst,
                            input axi_addr_t addr);
        if (m_awid !== id) report_mismatch("m_awid", 32'(m_awid), 32'(id));
        if (m_awlen !== len) report_mismatch("m_awlen", 32'(m_awlen), 32'(len));
        if (m_awburst !== burst) report_mismatch("m_awburst", 32'(m_awburst), 32'(burst));
        if (m_awaddr !== addr) report_mismatch("m_awaddr", m_awaddr, addr);
    endtask

    task automatic check_beat(input udp_word_t data, input logic last);
        if (m_wdata !== data) report_mismatch("m_wdata", m_wdata, data);
        if (m_wlast !== last) report_mismatch("m_wlast", 32'(m_wlast), 32'(last));
    endtask

    task automatic check_resp_word(input udp_word_t exp);
        if (udp_tx_data !== exp) report_mismatch("udp_tx_data", udp_tx_data, exp);
    endtask

    task automatic check_byte_num(input logic [15:0] got, input int max_words);
        string range;
        range = $sformatf("a multiple of 4 from 4 to %0d", 4 * max_words);
        if (got == 16'd0 || got[1:0] != 2'b00 || int'(got) > 4 * max_words) begin
            abort_run($sformatf("ERROR at %0t: udp_tx_byte_num is %0d, expected %s",
                                $time, got, range));
        end
    endtask

    function automatic udp_word_t desc_high(input stim_t s);
        udp_word_t w;
        w        = '0;
        w[31:24] = s.opcode;
        w[23:22] = s.burst;
        w[21:20] = s.id;
        w[16]    = s.wr;
        w[15:8]  = s.len;
        return w;
    endfunction

    function automatic udp_word_t resp_word(input axi_id_t id, input axi_resp_t resp);
        udp_word_t w;
        w        = '0;
        w[31:24] = 8'hF0;   // response marker
        w[17:16] = id;
        w[9:8]   = resp;
        return w;
    endfunction

    function automatic logic expects_write(input stim_t s);
        return (s.opcode == 8'h00) && s.wr;
    endfunction

    task automatic add_entry(input int idx, input logic [7:0] op, input logic wr,
                             input axi_id_t id, input axi_len_t len, input axi_burst_t burst,
                             input axi_addr_t addr, input logic [2:0] n, input axi_id_t rid,
                             input axi_resp_t rresp);
        stim_t s;
        s = '{op, wr, id, len, burst, addr, n, '0, rid, rresp};
        for (int k = 0; k < 4; k++) begin
            s.payload[k] = $random(seed);
        end
        stim[idx] = s;
    endtask

    task automatic load_stimulus();
        add_entry(0, 8'h00, 1'b1, 2'd1, 8'd3, 2'b01, 32'h0000_1000, 3'd4, 2'd1, 2'b00);
        add_entry(1, 8'h00, 1'b1, 2'd2, 8'd0, 2'b01, 32'h0000_2040, 3'd1, 2'd2, 2'b10);
        add_entry(2, 8'h00, 1'b0, 2'd3, 8'd1, 2'b01, 32'h0000_3000, 3'd2, 2'd3, 2'b00); // read
        add_entry(3, 8'h00, 1'b1, 2'd3, 8'd1, 2'b00, 32'hA000_0004, 3'd2, 2'd3, 2'b11);
        add_entry(4, 8'h01, 1'b1, 2'd0, 8'd2, 2'b01, 32'h0000_5000, 3'd3, 2'd0, 2'b00); // bad op
        add_entry(5, 8'h00, 1'b1, 2'd0, 8'd2, 2'b10, 32'hFFFF_FFF0, 3'd3, 2'd0, 2'b01);
        add_entry(6, 8'h00, 1'b1, 2'd2, 8'd3, 2'b01, 32'h1234_5678, 3'd4, 2'd2, 2'b00);
        add_entry(7, 8'h00, 1'b1, 2'd1, 8'd0, 2'b01, 32'h8000_0000, 3'd1, 2'd1, 2'b10);
    endtask

    task automatic send_word(input udp_word_t w, input logic last);
        udp_rx_en   = 1'b1;
        udp_rx_data = w;
        udp_rx_done = last;
        next_cycle();
    endtask

    task automatic idle_gap();
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        next_cycle();
    endtask

    task automatic send_cmd_packet(input int first);
        send_word({mark_cmd, 24'h0}, 1'b0);
        for (int i = first; i < first + BATCH; i++) begin
            send_word(desc_high(stim[i]), 1'b0);
            send_word(stim[i].addr, i == first + BATCH - 1);   // low word is the address
        end
        idle_gap();
    endtask

    task automatic send_data_packet(input stim_t s);
        send_word({mark_wdata, 24'h5A5A5A}, 1'b0);
        for (int k = 0; k < int'(s.nwords); k++) begin
            send_word(s.payload[k], k == int'(s.nwords) - 1);
        end
        idle_gap();
    endtask

    task automatic accept_aw(input stim_t s);
        int stall;
        int guard;
        stall = $random(seed) & 3;
        guard = 0;
        while (!m_awvalid) begin
            next_cycle();
            guard++;
            if (guard > TIMEOUT) abort_run("timeout waiting for m_awvalid");
        end
        while (stall > 0) begin   // fields must hold while ready is low
            check_aw(s.id, s.len, s.burst, s.addr);
            next_cycle();
            if (!m_awvalid) abort_run("m_awvalid dropped before the handshake");
            stall--;
        end
        check_aw(s.id, s.len, s.burst, s.addr);
        m_awready = 1'b1;
        next_cycle();
        m_awready = 1'b0;
    endtask

    task automatic accept_beats(input stim_t s);
        int stall;
        int guard;
        for (int k = 0; k < int'(s.nwords); k++) begin
            stall = $random(seed) & 3;
            guard = 0;
            while (!m_wvalid) begin
                next_cycle();
                guard++;
                if (guard > TIMEOUT) abort_run("timeout waiting for m_wvalid");
            end
            while (stall > 0) begin
                check_beat(s.payload[k], k == int'(s.nwords) - 1);
                next_cycle();
                if (!m_wvalid) abort_run("m_wvalid dropped before the handshake");
                stall--;
            end
            check_beat(s.payload[k], k == int'(s.nwords) - 1);
            m_wready = 1'b1;
            next_cycle();
            m_wready = 1'b0;
        end
    endtask

    task automatic return_resp(input stim_t s);
        int guard;
        guard    = 0;
        m_bid    = s.rid;
        m_bresp  = s.rresp;
        m_bvalid = 1'b1;
        while (!m_bready) begin
            next_cycle();
            guard++;
            if (guard > TIMEOUT) abort_run("timeout waiting for m_bready");
        end
        next_cycle();   // handshake on this edge
        m_bvalid = 1'b0;
        exp_resp.push_back(resp_word(s.rid, s.rresp));
    endtask

    task automatic drain_tx();
        int          guard;
        logic [15:0] bytes;
        while (exp_resp.size() > 0) begin
            guard = 0;
            while (tx_bytes.size() == 0) begin
                next_cycle();
                guard++;
                if (guard > TIMEOUT) abort_run("timeout waiting for udp_tx_start");
            end
            bytes = tx_bytes.pop_front();
            check_byte_num(bytes, exp_resp.size());
            for (int k = 0; k < int'(bytes) / 4; k++) begin
                check_resp_word(exp_resp.pop_front());
                udp_tx_req = 1'b1;
                next_cycle();
                udp_tx_req = 1'b0;
            end
            udp_tx_done = 1'b1;
            next_cycle();
            udp_tx_done = 1'b0;
        end
    endtask

    initial begin
        int writes;
        int guard;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
        udp_tx_req  = 1'b0;
        udp_tx_done = 1'b0;
        m_awready   = 1'b0;
        m_wready    = 1'b0;
        m_bid       = '0;
        m_bresp     = '0;
        m_bvalid    = 1'b0;
        writes      = 0;
        guard       = 0;
        load_stimulus();
        while (rstn !== 1'b1) begin
            next_cycle();
            guard++;
            if (guard > TIMEOUT) abort_run("reset was never released");
        end
        if (m_awvalid !== 1'b0) report_mismatch("m_awvalid", 32'(m_awvalid), 32'd0);
        if (m_wvalid !== 1'b0) report_mismatch("m_wvalid", 32'(m_wvalid), 32'd0);
        if (udp_tx_start !== 1'b0) report_mismatch("udp_tx_start", 32'(udp_tx_start), 32'd0);
        if (udp_tx_byte_num !== 16'd0) begin
            report_mismatch("udp_tx_byte_num", 32'(udp_tx_byte_num), 32'd0);
        end
        guard = 0;
        while (m_bready !== 1'b1) begin
            next_cycle();
            guard++;
            if (guard > TIMEOUT) abort_run("m_bready did not rise after reset");
        end
        for (int b = 0; b < NUM_ENTRIES; b += BATCH) begin
            send_cmd_packet(b);
            for (int i = b; i < b + BATCH; i++) begin
                send_data_packet(stim[i]);
            end
            for (int i = b; i < b + BATCH; i++) begin
                if (expects_write(stim[i])) begin
                    accept_aw(stim[i]);
                    writes++;
                end
            end
            for (int i = b; i < b + BATCH; i++) begin
                accept_beats(stim[i]);
            end
            if (m_awvalid !== 1'b0) abort_run("address transfer issued for a discarded descriptor");
            for (int i = b; i < b + BATCH; i++) begin
                if (expects_write(stim[i])) begin
                    return_resp(stim[i]);
                end
            end
            drain_tx();
        end
        repeat (5) next_cycle();
        if (aw_seen != writes) report_mismatch("address transfer count", aw_seen, writes);
        if (m_wvalid !== 1'b0) abort_run("write-data beat left over after all payloads");
        if (tx_bytes.size() != 0) abort_run("udp packet started with no response queued");
        $display("Verification passed");
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen (
    output logic gmii_rx_clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        gmii_rx_clk = 1'b0;
        forever #50 gmii_rx_clk = ~gmii_rx_clk;   // 100 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (5) @(posedge gmii_rx_clk);
        #10;
        rstn = 1'b1;   // release away from the edge
    end

endmodule

/* design/udp_axi_bridge.sv */
module udp_axi_bridge (
    input  logic                    gmii_rx_clk,
    input  logic                    rstn,
    input  logic                    udp_rx_en,
    input  logic                    udp_rx_done,
    input  udp_axi_pkg::udp_word_t  udp_rx_data,
    output logic                    udp_tx_start,
    output logic [15:0]             udp_tx_byte_num,
    output udp_axi_pkg::udp_word_t  udp_tx_data,
    input  logic                    udp_tx_req,
    input  logic                    udp_tx_done,
    output udp_axi_pkg::axi_id_t    m_awid,
    output udp_axi_pkg::axi_addr_t  m_awaddr,
    output udp_axi_pkg::axi_len_t   m_awlen,
    output udp_axi_pkg::axi_burst_t m_awburst,
    output logic                    m_awvalid,
    input  logic                    m_awready,
    output udp_axi_pkg::udp_word_t  m_wdata,
    output logic                    m_wlast,
    output logic                    m_wvalid,
    input  logic                    m_wready,
    input  udp_axi_pkg::axi_id_t    m_bid,
    input  udp_axi_pkg::axi_resp_t  m_bresp,
    input  logic                    m_bvalid,
    output logic                    m_bready
);
    import udp_axi_pkg::*;

    logic      desc_push;
    aw_desc_t  desc;
    logic      wdata_push;
    udp_word_t wdata;
    logic      wdata_last;

    cmd_parser u_cmd_parser (
        .gmii_rx_clk, .rstn, .udp_rx_en, .udp_rx_done, .udp_rx_data,
        .desc_push, .desc, .wdata_push, .wdata, .wdata_last
    );

    wr_addr_issue u_wr_addr_issue (
        .gmii_rx_clk, .rstn, .desc_push, .desc, .m_awready,
        .m_awid, .m_awaddr, .m_awlen, .m_awburst, .m_awvalid
    );

    wr_data_issue u_wr_data_issue (
        .gmii_rx_clk, .rstn, .wdata_push, .wdata, .wdata_last, .m_wready,
        .m_wdata, .m_wlast, .m_wvalid
    );

    // responses go back as the only udp sender
    wr_resp_report u_wr_resp_report (
        .gmii_rx_clk, .rstn, .m_bid, .m_bresp, .m_bvalid, .udp_tx_req, .udp_tx_done,
        .m_bready, .udp_tx_start, .udp_tx_byte_num, .udp_tx_data
    );

endmodule

/* design/wr_resp_report.sv */
`include "udp_axi_config.svh"

module wr_resp_report (
    input  logic                   gmii_rx_clk,
    input  logic                   rstn,
    input  udp_axi_pkg::axi_id_t   m_bid,
    input  udp_axi_pkg::axi_resp_t m_bresp,
    input  logic                   m_bvalid,
    input  logic                   udp_tx_req,
    input  logic                   udp_tx_done,
    output logic                   m_bready,
    output logic                   udp_tx_start,
    output logic [15:0]            udp_tx_byte_num,
    output udp_axi_pkg::udp_word_t udp_tx_data
);
    import udp_axi_pkg::*;

    localparam int CW = $clog2(`UAB_RESP_DEPTH + 1);

    typedef enum logic {
        tx_idle,
        tx_busy
    } tx_state_t;

    tx_state_t     tx_state;
    udp_word_t     resp_word;
    logic          resp_push;
    logic          resp_pop;
    logic          resp_empty;
    logic          resp_full;
    logic [CW-1:0] resp_count;

    // leave room for the word still in the capture register
    assign m_bready = !resp_full && !(resp_push && resp_count == CW'(`UAB_RESP_DEPTH - 1));
    assign resp_pop = (tx_state == tx_busy) && udp_tx_req;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            resp_push <= 1'b0;
        end else begin
            resp_push <= m_bvalid && m_bready;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (m_bvalid && m_bready) begin
            resp_word <= {`UAB_MARK_RESP, 6'b0, m_bid, 6'b0, m_bresp, 8'h00};
        end
    end

    sync_fifo #(
        .WIDTH (`UAB_WORD_W),
        .DEPTH (`UAB_RESP_DEPTH)
    ) u_resp_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (resp_push),
        .push_data   (resp_word),
        .pop         (resp_pop),
        .head        (udp_tx_data),
        .empty       (resp_empty),
        .full        (resp_full),
        .count       (resp_count)
    );

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            tx_state        <= tx_idle;
            udp_tx_start    <= 1'b0;
            udp_tx_byte_num <= '0;
        end else begin
            udp_tx_start <= 1'b0;
            case (tx_state)
                tx_idle: begin
                    if (!resp_empty) begin
                        udp_tx_start    <= 1'b1;
                        udp_tx_byte_num <= 16'({resp_count, 2'b00});  // four bytes a word
                        tx_state        <= tx_busy;
                    end
                end
                tx_busy: begin
                    if (udp_tx_done) begin
                        tx_state <= tx_idle;
                    end
                end
                default: tx_state <= tx_idle;
            endcase
        end
    end

endmodule

/* design/wr_data_issue.sv */
`include "udp_axi_config.svh"

module wr_data_issue (
    input  logic                   gmii_rx_clk,
    input  logic                   rstn,
    input  logic                   wdata_push,
    input  udp_axi_pkg::udp_word_t wdata,
    input  logic                   wdata_last,
    input  logic                   m_wready,
    output udp_axi_pkg::udp_word_t m_wdata,
    output logic                   m_wlast,
    output logic                   m_wvalid
);
    logic [`UAB_WORD_W:0] beat_head;   // {last, data}
    logic                 beat_empty;
    logic                 beat_pop;

    assign m_wvalid          = !beat_empty;
    assign {m_wlast, m_wdata} = beat_head;
    assign beat_pop          = m_wvalid && m_wready;  // one beat per handshake

    sync_fifo #(
        .WIDTH (`UAB_WORD_W + 1),
        .DEPTH (`UAB_WDATA_DEPTH)
    ) u_beat_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (wdata_push),
        .push_data   ({wdata_last, wdata}),
        .pop         (beat_pop),
        .head        (beat_head),
        .empty       (beat_empty),
        .full        (),
        .count       ()
    );

endmodule

/* design/wr_addr_issue.sv */
`include "udp_axi_config.svh"

module wr_addr_issue (
    input  logic                    gmii_rx_clk,
    input  logic                    rstn,
    input  logic                    desc_push,
    input  udp_axi_pkg::aw_desc_t   desc,
    input  logic                    m_awready,
    output udp_axi_pkg::axi_id_t    m_awid,
    output udp_axi_pkg::axi_addr_t  m_awaddr,
    output udp_axi_pkg::axi_len_t   m_awlen,
    output udp_axi_pkg::axi_burst_t m_awburst,
    output logic                    m_awvalid
);
    import udp_axi_pkg::*;

    localparam int DESC_W = $bits(aw_desc_t);

    aw_desc_t desc_head;
    logic     desc_empty;
    logic     desc_pop;

    // next descriptor only once the previous address has been taken
    assign desc_pop = !desc_empty && !m_awvalid;

    sync_fifo #(
        .WIDTH (DESC_W),
        .DEPTH (`UAB_DESC_DEPTH)
    ) u_desc_fifo (
        .gmii_rx_clk (gmii_rx_clk),
        .rstn        (rstn),
        .push        (desc_push),
        .push_data   (desc),
        .pop         (desc_pop),
        .head        (desc_head),
        .empty       (desc_empty),
        .full        (),
        .count       ()
    );

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            m_awvalid <= 1'b0;
        end else if (desc_pop) begin
            m_awvalid <= 1'b1;
        end else if (m_awready) begin
            m_awvalid <= 1'b0;   // drop in the cycle after the handshake
        end
    end

    // fields held stable while valid waits for ready
    always_ff @(posedge gmii_rx_clk) begin
        if (desc_pop) begin
            m_awid    <= desc_head.id;
            m_awaddr  <= desc_head.addr;
            m_awlen   <= desc_head.len;
            m_awburst <= desc_head.burst;
        end
    end

endmodule

/* design/cmd_parser.sv */
module cmd_parser (
    input  logic                   gmii_rx_clk,
    input  logic                   rstn,
    input  logic                   udp_rx_en,
    input  logic                   udp_rx_done,
    input  udp_axi_pkg::udp_word_t udp_rx_data,
    output logic                   desc_push,
    output udp_axi_pkg::aw_desc_t  desc,
    output logic                   wdata_push,
    output udp_axi_pkg::udp_word_t wdata,
    output logic                   wdata_last
);
    import udp_axi_pkg::*;

    parse_state_t state;
    logic         skip;       // drop words of an unknown packet until done
    logic         phase;      // 0 expects high word, 1 expects low word
    udp_word_t    hi_word;    // held high word of the current descriptor
    logic         cmd_word;
    logic         is_write;

    assign cmd_word = udp_rx_en && (state == cmd);

    // opcode 8'h00 with the write flag set goes to the address queue
    assign is_write = (hi_word[31:24] == 8'h00) && hi_word[16];

    // payload words pass straight through to the data queue
    assign wdata_push = udp_rx_en && (state == udp_axi_pkg::wdata);
    assign wdata      = udp_rx_data;
    assign wdata_last = udp_rx_done;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state <= idle;
            skip  <= 1'b0;
            phase <= 1'b0;
        end else if (udp_rx_en) begin
            case (state)
                idle: begin
                    phase <= 1'b0;
                    if (skip) begin
                        skip <= !udp_rx_done;   // resync at end of packet
                    end else if (!udp_rx_done) begin
                        if (udp_rx_data[31:24] == mark_cmd) begin
                            state <= cmd;
                        end else if (udp_rx_data[31:24] == mark_wdata) begin
                            state <= udp_axi_pkg::wdata;
                        end else begin
                            skip <= 1'b1;
                        end
                    end
                end
                cmd: begin
                    if (udp_rx_done) begin
                        state <= idle;
                        phase <= 1'b0;
                    end else begin
                        phase <= !phase;
                    end
                end
                udp_axi_pkg::wdata: begin
                    if (udp_rx_done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            desc_push <= 1'b0;
        end else begin
            desc_push <= cmd_word && phase && is_write;  // one cycle after low word
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (cmd_word && !phase) begin
            hi_word <= udp_rx_data;
        end
        if (cmd_word && phase) begin
            desc.burst <= hi_word[23:22];
            desc.id    <= hi_word[21:20];
            desc.len   <= hi_word[15:8];
            desc.addr  <= udp_rx_data;   // low word is the address
        end
    end

endmodule

/* design/sync_fifo.sv */
module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                       gmii_rx_clk,
    input  logic                       rstn,
    input  logic                       push,
    input  logic [WIDTH-1:0]           push_data,
    input  logic                       pop,
    output logic [WIDTH-1:0]           head,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // push into a full queue is lost
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign head    = mem[rd_ptr];     // show-ahead of the oldest entry

    always_ff @(posedge gmii_rx_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
            count <= count + CW'(do_push) - CW'(do_pop);  // both may happen together
        end
    end

endmodule

/* design/udp_axi_pkg.sv */
`include "udp_axi_config.svh"

package udp_axi_pkg;

    typedef logic [`UAB_WORD_W-1:0] udp_word_t;   // one udp word
    typedef logic [`UAB_ADDR_W-1:0] axi_addr_t;
    typedef logic [`UAB_ID_W-1:0]   axi_id_t;
    typedef logic [`UAB_LEN_W-1:0]  axi_len_t;
    typedef logic [1:0]             axi_burst_t;  // fixed, incr, wrap
    typedef logic [1:0]             axi_resp_t;

    // top byte of the first word of a received packet
    typedef enum logic [7:0] {
        mark_cmd   = 8'h00,
        mark_wdata = 8'hFF
    } pkt_mark_t;

    typedef enum logic [1:0] {
        idle,
        cmd,
        wdata
    } parse_state_t;

    typedef struct packed {
        axi_burst_t burst;
        axi_id_t    id;
        axi_len_t   len;
        axi_addr_t  addr;
    } aw_desc_t;  // 44 bits

endpackage

/* design/udp_axi_config.svh */
`ifndef UDP_AXI_CONFIG_SVH
`define UDP_AXI_CONFIG_SVH

// word and field widths
`define UAB_WORD_W 32   // udp word and axi data
`define UAB_ADDR_W 32   // axi address
`define UAB_ID_W 2      // axi id
`define UAB_LEN_W 8     // burst length in beats minus one

// queue depths
`define UAB_DESC_DEPTH 16    // write-address descriptors
`define UAB_WDATA_DEPTH 512  // payload beats
`define UAB_RESP_DEPTH 16    // response words

// marker byte in bits 31:24 of every response word
`define UAB_MARK_RESP 8'hF0

`endif
